//--- all.f
source/icache_pkg.sv
source/icache_array_if.sv
source/icache_array.sv
source/icache_hit_select.sv
source/icache_fetch_ctrl.sv
source/icache_top.sv
testbench/icache_assertions.sv
testbench/tb_icache.sv

//--- run.sh
#!/bin/sh
# Compile and run the instruction cache testbench, then look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_icache \
  -f all.f -o sim_icache > build.log 2>&1 &&
./obj_dir/sim_icache > sim.log 2>&1
grep -q '^>>> PASS$' sim.log 2>/dev/null || { echo "simulation failed, see build.log and sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- source/icache_array.sv
// Tag, valid and line storage per way with registered read and single-way refill write
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
  parameter int unsigned NUM_WAYS = 2
) (
  input  wire                                     clk_i,
  input  wire                                     rst_ni,
  icache_array_if.array                           arr,
  output icache_pkg::tag_t  [NUM_WAYS-1:0]        rd_tags_o,
  output logic              [NUM_WAYS-1:0]        rd_valid_o,
  output icache_pkg::line_t [NUM_WAYS-1:0]        rd_lines_o
);
  import icache_pkg::*;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // ------------------------------------------------------------
    // Storage of one way
    // ------------------------------------------------------------
    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    logic  way_we;
    logic  fwd;
    tag_t  rd_tag_q;
    line_t rd_line_q;
    logic  rd_valid_q;

    // Refill targets this way
    assign way_we = arr.wr_en && (arr.wr_way == way_t'(w));
    // Same-set write in the read cycle, hand the new contents straight to the read register
    assign fwd    = way_we && (arr.wr_index == arr.rd_index);

    // Tags and lines carry no reset
    always_ff @(posedge clk_i) begin
      if (way_we) begin
        tag_mem[arr.wr_index]  <= arr.wr_tag;
        line_mem[arr.wr_index] <= arr.wr_line;
      end
      rd_tag_q  <= fwd ? arr.wr_tag  : tag_mem[arr.rd_index];
      rd_line_q <= fwd ? arr.wr_line : line_mem[arr.rd_index];
    end

    // Valid bits start cleared
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q    <= '0;
        rd_valid_q <= 1'b0;
      end else begin
        if (way_we) begin
          valid_q[arr.wr_index] <= 1'b1;
        end
        rd_valid_q <= fwd | valid_q[arr.rd_index];
      end
    end

    assign rd_tags_o[w]  = rd_tag_q;
    assign rd_lines_o[w] = rd_line_q;
    assign rd_valid_o[w] = rd_valid_q;
  end

endmodule

`default_nettype wire

//--- source/icache_array_if.sv
// Array access bundle: lookup read index plus refill write port, with modports
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if;
  import icache_pkg::*;

  // Read side, index of the set to look up next cycle
  index_t rd_index;

  // Refill write side
  logic   wr_en;
  way_t   wr_way;
  index_t wr_index;
  tag_t   wr_tag;
  line_t  wr_line;

  // Controller owns every signal
  modport ctrl (output rd_index, wr_en, wr_way, wr_index, wr_tag, wr_line);

  // Storage side only listens
  modport array (input rd_index, wr_en, wr_way, wr_index, wr_tag, wr_line);

endinterface

`default_nettype wire

//--- source/icache_fetch_ctrl.sv
// Fetch FSM with request and miss context, response register and channel handshakes
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl #(
  parameter int unsigned FETCH_NUM = 2
) (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 flush_i,
  // Request channel
  input  wire                                 req_valid_i,
  output logic                                req_ready_o,
  input  icache_pkg::pc_t                     req_pc_i,
  // Response channel
  output logic                                rsp_valid_o,
  input  wire                                 rsp_ready_i,
  output icache_pkg::instr_t [FETCH_NUM-1:0]  rsp_instrs_o,
  // Miss request channel
  output logic                                miss_valid_o,
  input  wire                                 miss_ready_i,
  output icache_pkg::pc_t                     miss_paddr_o,
  output icache_pkg::way_t                    miss_way_o,
  // Refill channel
  input  wire                                 refill_valid_i,
  output logic                                refill_ready_o,
  input  icache_pkg::pc_t                     refill_paddr_i,
  input  icache_pkg::way_t                    refill_way_i,
  input  icache_pkg::line_t                   refill_line_i,
  // Array and hit logic
  icache_array_if.ctrl                        arr,
  input  wire                                 hit_i,
  input  icache_pkg::instr_t [FETCH_NUM-1:0]  instrs_i,
  input  icache_pkg::way_t                    victim_i,
  output icache_pkg::tag_t                    exp_tag_o,
  output icache_pkg::slot_t                   slot_o
);
  import icache_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        drop_q;
  logic        rsp_valid_q;
  logic        req_fire;
  logic        refill_fire;

  // Request and miss context, payload only
  tag_t   tag_q;
  index_t index_q;
  slot_t  slot_q;
  pc_t    miss_paddr_q;
  way_t   miss_way_q;
  instr_t [FETCH_NUM-1:0] rsp_instrs_q;

  // ------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------
  // No accept while a flush is asserted
  assign req_ready_o    = (state_q == IDLE) && !flush_i;
  assign miss_valid_o   = (state_q == MISS_REQ);
  assign refill_ready_o = (state_q == MISS_WAIT_REFILL);
  assign rsp_valid_o    = rsp_valid_q;
  assign req_fire       = req_valid_i && req_ready_o;
  assign refill_fire    = refill_valid_i && refill_ready_o;

  // Index goes to the array in the accept cycle, so data is there in LOOKUP
  assign arr.rd_index = req_fire ? req_pc_i[OFFSET_W +: INDEX_W] : index_q;

  // Refill write, set and tag both come from the refill address
  assign arr.wr_en    = refill_fire;
  assign arr.wr_way   = refill_way_i;
  assign arr.wr_index = refill_paddr_i[OFFSET_W +: INDEX_W];
  assign arr.wr_tag   = refill_paddr_i[PLEN-1 -: TAG_W];
  assign arr.wr_line  = refill_line_i;

  assign exp_tag_o    = tag_q;
  assign slot_o       = slot_q;
  assign miss_paddr_o = miss_paddr_q;
  assign miss_way_o   = miss_way_q;
  assign rsp_instrs_o = rsp_instrs_q;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:             if (req_fire) state_d = LOOKUP;
      LOOKUP:           state_d = hit_i ? RESPOND : MISS_REQ;
      MISS_REQ:         if (miss_ready_i) state_d = MISS_WAIT_REFILL;
      // A flushed miss still takes its refill, then ends silently
      MISS_WAIT_REFILL: if (refill_fire) state_d = (drop_q || flush_i) ? IDLE : LOOKUP;
      RESPOND:          if (rsp_ready_i) state_d = IDLE;
      default:          state_d = IDLE;
    endcase
    // Flush wins, except once the miss has gone out to memory
    if (flush_i && (state_q != MISS_WAIT_REFILL) &&
        !(state_q == MISS_REQ && miss_ready_i)) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      drop_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= (state_d == RESPOND);
      // Remember a flush that hit an outstanding miss
      if (refill_fire) begin
        drop_q <= 1'b0;
      end else if (flush_i && (state_d == MISS_WAIT_REFILL)) begin
        drop_q <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Context and response registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      tag_q   <= req_pc_i[PLEN-1 -: TAG_W];
      index_q <= req_pc_i[OFFSET_W +: INDEX_W];
      slot_q  <= req_pc_i[OFFSET_W-1 -: SLOT_W];
    end
    if (state_q == LOOKUP && hit_i) begin
      rsp_instrs_q <= instrs_i;
    end
    // Line-aligned miss address plus the way chosen at lookup
    if (state_q == LOOKUP && !hit_i) begin
      miss_paddr_q <= {tag_q, index_q, {OFFSET_W{1'b0}}};
      miss_way_q   <= victim_i;
    end
  end

endmodule

`default_nettype wire

//--- source/icache_hit_select.sv
// Tag compare, hit way choice, fetch-group extraction and victim way choice
`timescale 1ns/1ps
`default_nettype none

module icache_hit_select #(
  parameter int unsigned NUM_WAYS  = 2,
  parameter int unsigned FETCH_NUM = 2
) (
  input  wire                                    clk_i,
  input  wire                                    rst_ni,
  input  icache_pkg::tag_t   [NUM_WAYS-1:0]      tags_i,
  input  wire                [NUM_WAYS-1:0]      valid_i,
  input  icache_pkg::line_t  [NUM_WAYS-1:0]      lines_i,
  input  icache_pkg::tag_t                       exp_tag_i,
  input  icache_pkg::slot_t                      slot_i,
  output logic                                   hit_o,
  output icache_pkg::instr_t [FETCH_NUM-1:0]     instrs_o,
  output icache_pkg::way_t                       victim_o
);
  import icache_pkg::*;

  logic [NUM_WAYS-1:0] match;
  way_t                hit_way;
  way_t                first_inv;
  line_t               sel_line;
  logic [3:0]          lfsr_q;

  // ------------------------------------------------------------
  // Hit detection, lowest matching way wins
  // ------------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign match[w] = valid_i[w] && (tags_i[w] == exp_tag_i);
  end

  always_comb begin
    hit_way   = '0;
    first_inv = '0;
    // Walk downwards so the lowest index is the last one written
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way = way_t'(w);
      end
      if (!valid_i[w]) begin
        first_inv = way_t'(w);
      end
    end
  end

  assign hit_o    = |match;
  assign sel_line = lines_i[hit_way];

  // Group is aligned, so slot plus offset stays inside the line
  always_comb begin
    slot_t word_sel;
    for (int i = 0; i < FETCH_NUM; i++) begin
      word_sel    = slot_i + slot_t'(i);
      instrs_o[i] = sel_line[ILEN*word_sel +: ILEN];
    end
  end

  // ------------------------------------------------------------
  // Victim choice
  // ------------------------------------------------------------
  // Free-running x^4 + x^3 + 1 sequence, never all zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 4'b0001;
    end else begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  // Empty way first, else a pseudo-random one folded onto the way count
  assign victim_o = (&valid_i) ? (lfsr_q[WAY_W-1:0] & way_t'(NUM_WAYS - 1)) : first_inv;

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
// Instruction cache geometry constants, vector types and controller state encoding
`default_nettype none

package icache_pkg;

  // ------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------
  localparam int unsigned PLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned NUM_SETS   = 16;
  localparam int unsigned MAX_WAYS   = 4;

  // Derived address field widths
  localparam int unsigned OFFSET_W = $clog2(LINE_WORDS * ILEN / 8);
  localparam int unsigned INDEX_W  = $clog2(NUM_SETS);
  localparam int unsigned TAG_W    = PLEN - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_W    = $clog2(MAX_WAYS);
  localparam int unsigned SLOT_W   = $clog2(LINE_WORDS);

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [PLEN-1:0]            pc_t;
  typedef logic [ILEN-1:0]            instr_t;
  typedef logic [LINE_WORDS*ILEN-1:0] line_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [INDEX_W-1:0]         index_t;
  typedef logic [WAY_W-1:0]           way_t;
  typedef logic [SLOT_W-1:0]          slot_t;

  // Fetch controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT_REFILL,
    RESPOND
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/icache_top.sv
// Instruction cache top level with plain channel ports
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int unsigned NUM_WAYS  = 2,
  parameter int unsigned FETCH_NUM = 2
) (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 flush_i,
  // Fetch request
  input  wire                                 req_valid_i,
  output logic                                req_ready_o,
  input  icache_pkg::pc_t                     req_pc_i,
  // Fetch response
  output logic                                rsp_valid_o,
  input  wire                                 rsp_ready_i,
  output icache_pkg::instr_t [FETCH_NUM-1:0]  rsp_instrs_o,
  // Miss request to memory
  output logic                                miss_valid_o,
  input  wire                                 miss_ready_i,
  output icache_pkg::pc_t                     miss_paddr_o,
  output icache_pkg::way_t                    miss_way_o,
  // Refill from memory
  input  wire                                 refill_valid_i,
  output logic                                refill_ready_o,
  input  icache_pkg::pc_t                     refill_paddr_i,
  input  icache_pkg::way_t                    refill_way_i,
  input  icache_pkg::line_t                   refill_line_i
);
  import icache_pkg::*;

  // Array read outputs, one entry per way
  tag_t  [NUM_WAYS-1:0]  rd_tags;
  logic  [NUM_WAYS-1:0]  rd_valid;
  line_t [NUM_WAYS-1:0]  rd_lines;

  // Hit logic results
  logic                  hit;
  instr_t [FETCH_NUM-1:0] instrs;
  way_t                  victim;
  tag_t                  exp_tag;
  slot_t                 slot;

  icache_array_if u_arr_if ();

  icache_array #(
    .NUM_WAYS (NUM_WAYS)
  ) u_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .arr        (u_arr_if.array),
    .rd_tags_o  (rd_tags),
    .rd_valid_o (rd_valid),
    .rd_lines_o (rd_lines)
  );

  icache_hit_select #(
    .NUM_WAYS  (NUM_WAYS),
    .FETCH_NUM (FETCH_NUM)
  ) u_hit_select (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tags_i    (rd_tags),
    .valid_i   (rd_valid),
    .lines_i   (rd_lines),
    .exp_tag_i (exp_tag),
    .slot_i    (slot),
    .hit_o     (hit),
    .instrs_o  (instrs),
    .victim_o  (victim)
  );

  icache_fetch_ctrl #(
    .FETCH_NUM (FETCH_NUM)
  ) u_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_pc_i       (req_pc_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_instrs_o   (rsp_instrs_o),
    .miss_valid_o   (miss_valid_o),
    .miss_ready_i   (miss_ready_i),
    .miss_paddr_o   (miss_paddr_o),
    .miss_way_o     (miss_way_o),
    .refill_valid_i (refill_valid_i),
    .refill_ready_o (refill_ready_o),
    .refill_paddr_i (refill_paddr_i),
    .refill_way_i   (refill_way_i),
    .refill_line_i  (refill_line_i),
    .arr            (u_arr_if.ctrl),
    .hit_i          (hit),
    .instrs_i       (instrs),
    .victim_i       (victim),
    .exp_tag_o      (exp_tag),
    .slot_o         (slot)
  );

endmodule

`default_nettype wire

//--- testbench/icache_assertions.sv
// Concurrent handshake assertions bound to the instruction cache top level
`timescale 1ns/1ps
`default_nettype none

module icache_assertions #(
  parameter int unsigned FETCH_NUM = 2
) (
  input wire                                 clk_i,
  input wire                                 rst_ni,
  input wire                                 flush_i,
  input wire                                 req_ready_i,
  input wire                                 rsp_valid_i,
  input wire                                 rsp_ready_i,
  input icache_pkg::instr_t [FETCH_NUM-1:0]  rsp_instrs_i,
  input wire                                 miss_valid_i,
  input wire                                 miss_ready_i,
  input icache_pkg::pc_t                     miss_paddr_i,
  input icache_pkg::way_t                    miss_way_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Stalled response keeps valid and data
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_i && !rsp_ready_i && !flush_i) |=> (rsp_valid_i && $stable(rsp_instrs_i)))
  else begin
    $error("response dropped or changed while stalled");
    fail_count++;
  end

  // Miss request held until memory takes it
  a_miss_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (miss_valid_i && !miss_ready_i && !flush_i) |=>
      (miss_valid_i && $stable(miss_paddr_i) && $stable(miss_way_i)))
  else begin
    $error("miss request dropped or changed before acceptance");
    fail_count++;
  end

  // New requests only once the response is gone
  a_ready_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_ready_i && rsp_valid_i))
  else begin
    $error("req_ready_o and rsp_valid_o high together");
    fail_count++;
  end

endmodule

bind icache_top icache_assertions #(
  .FETCH_NUM (FETCH_NUM)
) u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_i      (flush_i),
  .req_ready_i  (req_ready_o),
  .rsp_valid_i  (rsp_valid_o),
  .rsp_ready_i  (rsp_ready_i),
  .rsp_instrs_i (rsp_instrs_o),
  .miss_valid_i (miss_valid_o),
  .miss_ready_i (miss_ready_i),
  .miss_paddr_i (miss_paddr_o),
  .miss_way_i   (miss_way_o)
);

`default_nettype wire

//--- testbench/tb_icache.sv
// Testbench for the instruction cache: clock, reset, LFSR stimulus, memory model, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
  import icache_pkg::*;

  // ------------------------------------------------------------
  // Run parameters and memory model constants
  // ------------------------------------------------------------
  localparam int unsigned WAYS           = 2;
  localparam int unsigned FETCH          = 2;
  localparam int unsigned CLK_PERIOD     = 40;
  localparam int unsigned RESET_CYCLES   = 2;
  localparam int unsigned LINE_BYTES     = 16;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam pc_t         REGION_BASE    = 32'h0000_4000;
  // Set 5, four tags apart by 0x100
  localparam pc_t         VICTIM_BASE    = 32'h0002_0050;
  localparam int unsigned NUM_RAND       = 100;
  localparam int unsigned NUM_REQ        = 8 + 2 * NUM_RAND;
  localparam int unsigned CYCLES_PER_REQ = 100;
  localparam int unsigned WATCH_CYCLES   = RESET_CYCLES + 4 + NUM_REQ * CYCLES_PER_REQ;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               flush_i;
  logic               req_valid_i;
  logic               req_ready_o;
  pc_t                req_pc_i;
  logic               rsp_valid_o;
  logic               rsp_ready_i;
  instr_t [FETCH-1:0] rsp_instrs_o;
  logic               miss_valid_o;
  logic               miss_ready_i;
  pc_t                miss_paddr_o;
  way_t               miss_way_o;
  logic               refill_valid_i;
  logic               refill_ready_o;
  pc_t                refill_paddr_i;
  way_t               refill_way_i;
  line_t              refill_line_i;

  logic [15:0] lfsr = 16'd6;
  int unsigned check_count = 0;
  int unsigned err_count = 0;
  // Line address the current request must miss on
  pc_t         exp_line;
  // Memory side state of the refill responder
  logic        refill_pending = 1'b0;
  int unsigned refill_wait;
  pc_t         mem_paddr;
  way_t        mem_way;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  icache_top #(
    .NUM_WAYS  (WAYS),
    .FETCH_NUM (FETCH)
  ) dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_pc_i       (req_pc_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_instrs_o   (rsp_instrs_o),
    .miss_valid_o   (miss_valid_o),
    .miss_ready_i   (miss_ready_i),
    .miss_paddr_o   (miss_paddr_o),
    .miss_way_o     (miss_way_o),
    .refill_valid_i (refill_valid_i),
    .refill_ready_o (refill_ready_o),
    .refill_paddr_i (refill_paddr_i),
    .refill_way_i   (refill_way_i),
    .refill_line_i  (refill_line_i)
  );

  // Bound on the whole run, every request gets a worst-case budget
  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCH_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // ------------------------------------------------------------
  // Random numbers and memory model
  // ------------------------------------------------------------
  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Odd multiplier plus rotation spreads every address bit over the word
  function automatic instr_t model_word(input pc_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A0F_C3A5;
  endfunction

  function automatic line_t model_line(input pc_t line_addr);
    line_t l;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      l[32*i +: 32] = model_word(line_addr + pc_t'(4 * i));
    end
    return l;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input string what, input pc_t got, input pc_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // One clock edge, memory side serviced on the way
  // ------------------------------------------------------------
  task automatic tick();
    logic [31:0] v;
    @(posedge clk_i);
    // Miss handshake seen at this edge
    if (miss_valid_o && miss_ready_i) begin
      check_pc("miss_paddr_o", miss_paddr_o, exp_line);
      check_bit("miss_way_o below NUM_WAYS", int'(miss_way_o) < WAYS, 1'b1);
      mem_paddr = miss_paddr_o;
      mem_way   = miss_way_o;
      draw(3, v);
      refill_wait    = v;
      refill_pending = 1'b1;
    end
    if (refill_valid_i && refill_ready_o) begin
      refill_valid_i <= 1'b0;
    end else if (refill_pending) begin
      if (refill_wait == 0) begin
        refill_valid_i <= 1'b1;
        refill_paddr_i <= mem_paddr;
        refill_way_i   <= mem_way;
        refill_line_i  <= model_line(mem_paddr);
        refill_pending = 1'b0;
      end else begin
        refill_wait--;
      end
    end
    // Memory accepts misses about half the time
    draw(1, v);
    miss_ready_i <= v[0];
  endtask

  // Full request: accept, optional flush, response check, optional hit timing check
  task automatic fetch(input pc_t pc, input logic flush_it, input logic want_hit);
    logic [31:0] v;
    logic        accepted;
    logic        done;
    logic        miss_raised;
    int          lat;
    int          first_lat;
    exp_line    = {pc[31:4], 4'h0};
    req_valid_i <= 1'b1;
    req_pc_i    <= pc;
    rsp_ready_i <= 1'b0;
    accepted    = 1'b0;
    while (!accepted) begin
      tick();
      accepted = req_ready_o;
    end
    req_valid_i <= 1'b0;
    done        = 1'b0;
    miss_raised = 1'b0;
    lat         = 0;
    first_lat   = 0;
    while (!done) begin
      // Flushed requests keep rsp_ready low so RESPOND is still there to flush
      if (!flush_it) begin
        draw(2, v);
        rsp_ready_i <= (v[1:0] != 2'b00);
      end
      tick();
      lat++;
      if (miss_valid_o) begin
        miss_raised = 1'b1;
      end
      if (flush_it && (rsp_valid_o || miss_valid_o)) begin
        flush_i <= 1'b1;
        tick();
        flush_i <= 1'b0;
        tick();
        check_bit("rsp_valid_o after flush", rsp_valid_o, 1'b0);
        check_bit("miss_valid_o after flush", miss_valid_o, 1'b0);
        done = 1'b1;
      end else if (rsp_valid_o) begin
        if (first_lat == 0) begin
          first_lat = lat;
        end
        if (rsp_ready_i) begin
          for (int i = 0; i < FETCH; i++) begin
            check_instr($sformatf("rsp_instrs_o[%0d]", i), rsp_instrs_o[i],
                        model_word(pc + pc_t'(4 * i)));
          end
          done = 1'b1;
        end
      end
    end
    rsp_ready_i <= 1'b0;
    if (want_hit) begin
      check_bit("miss_valid_o on repeated request", miss_raised, 1'b0);
      check_count++;
      if (first_lat != 2) begin
        err_count++;
        $display("hit at pc %h answered %0d cycles after acceptance instead of 2", pc, first_lat);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] v;
    pc_t         pc;
    logic        fl;
    int unsigned base_err;
    int unsigned total_err;
    rst_ni         <= 1'b0;
    flush_i        <= 1'b0;
    req_valid_i    <= 1'b0;
    req_pc_i       <= '0;
    rsp_ready_i    <= 1'b0;
    miss_ready_i   <= 1'b0;
    refill_valid_i <= 1'b0;
    refill_paddr_i <= '0;
    refill_way_i   <= '0;
    refill_line_i  <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    base_err = err_count;
    tick();
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("miss_valid_o", miss_valid_o, 1'b0);
    check_bit("refill_ready_o", refill_ready_o, 1'b0);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    report_test("reset_state", base_err);

    // Four lines into one set of two ways, then read them all back
    base_err = err_count;
    for (int k = 0; k < 4; k++) begin
      fetch(VICTIM_BASE + pc_t'(k) * 32'h100, 1'b0, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      fetch(VICTIM_BASE + pc_t'(k) * 32'h100 + 32'h8, 1'b0, 1'b0);
    end
    report_test("set_victims", base_err);

    base_err = err_count;
    for (int n = 0; n < NUM_RAND; n++) begin
      // 64-line region, group aligned
      draw(6, v);
      pc = REGION_BASE + pc_t'(v) * LINE_BYTES;
      draw($clog2(WORDS_PER_LINE / FETCH), v);
      pc = pc + pc_t'(v * FETCH * 4);
      draw(3, v);
      fl = (v[2:0] == 3'b000);
      fetch(pc, fl, 1'b0);
      if (!fl) begin
        draw(2, v);
        if (v[1:0] == 2'b00) begin
          fetch(pc, 1'b0, 1'b1);
        end
      end
    end
    report_test("random_mix", base_err);

    total_err = err_count + dut0.u_assert.fail_count;
    $display("summary: %0d checks, %0d check errors, %0d assertion failures",
             check_count, err_count, dut0.u_assert.fail_count);
    if (total_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
